// ==== Bender.yml ====
package:
  name: sink_streamer

export_include_dirs:
  - design

sources:
  - files:
      - design/sink_pkg.sv
      - design/sink_cmd_decode.sv
      - design/sink_addr_gen.sv
      - design/sink_store_align.sv
      - design/sink_run_ctrl.sv
      - design/sink_top.sv
  - target: simulation
    files:
      - dv/tb_sink_top.sv

// ==== design/sink_addr_gen.sv ====
// Stride address generator
`include "sink_params.svh"

module sink_addr_gen (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  logic                    clear_i,
  input  logic                    gen_start_i,
  input  logic [`SINK_ADDR_W-1:0] base_i,
  input  logic [`SINK_ADDR_W-1:0] stride_i,
  input  logic [`SINK_CNT_W-1:0]  len_i,
  input  logic                    afifo_pop_i,
  output logic                    afifo_valid_o,
  output logic [`SINK_ADDR_W-1:0] afifo_addr_o,
  output logic                    gen_done_o
);

  localparam int unsigned AFIFO_DEPTH = `SINK_AFIFO_DEPTH;
  localparam int unsigned PTR_W       = (AFIFO_DEPTH > 1) ? $clog2(AFIFO_DEPTH) : 1;
  localparam int unsigned FILL_W      = $clog2(AFIFO_DEPTH + 1);

  logic [`SINK_ADDR_W-1:0] addr_q;
  logic [`SINK_CNT_W-1:0]  issue_cnt_q;
  logic [`SINK_CNT_W-1:0]  issue_cnt_nxt;
  logic                    issuing_q;
  logic                    push;
  logic                    last_push;

  logic [`SINK_ADDR_W-1:0] fifo_mem [AFIFO_DEPTH];
  logic [PTR_W-1:0]        wr_ptr_q;
  logic [PTR_W-1:0]        rd_ptr_q;
  logic [FILL_W-1:0]       fill_q;
  logic                    fifo_full;

  assign fifo_full     = (fill_q == FILL_W'(AFIFO_DEPTH));
  // One address per cycle while the run still has addresses to give
  assign push          = issuing_q && !fifo_full;
  assign issue_cnt_nxt = issue_cnt_q + 1'b1;
  assign last_push     = push && (issue_cnt_nxt == len_i);

  // A zero length run never issues and reports done right away
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      issuing_q   <= 1'b0;
      issue_cnt_q <= '0;
    end else if (clear_i) begin
      issuing_q   <= 1'b0;
      issue_cnt_q <= '0;
    end else if (gen_start_i) begin
      issuing_q   <= (len_i != '0);
      issue_cnt_q <= '0;
    end else if (push) begin
      issuing_q   <= !last_push;
      issue_cnt_q <= issue_cnt_nxt;
    end
  end

  // Running byte address, the next one to be pushed
  always_ff @(posedge clk_i) begin
    if (gen_start_i) begin
      addr_q <= base_i;
    end else if (push) begin
      addr_q <= addr_q + stride_i;
    end
  end

  // Address FIFO storage
  always_ff @(posedge clk_i) begin
    if (push) begin
      fifo_mem[wr_ptr_q] <= addr_q;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      fill_q   <= '0;
    end else if (clear_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      fill_q   <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= (wr_ptr_q == PTR_W'(AFIFO_DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (afifo_pop_i) begin
        rd_ptr_q <= (rd_ptr_q == PTR_W'(AFIFO_DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      // Fill level follows the net effect of push and pop
      case ({push, afifo_pop_i})
        2'b10:   fill_q <= fill_q + 1'b1;
        2'b01:   fill_q <= fill_q - 1'b1;
        default: fill_q <= fill_q;
      endcase
    end
  end

  assign afifo_valid_o = (fill_q != '0);
  assign afifo_addr_o  = fifo_mem[rd_ptr_q];
  assign gen_done_o    = !issuing_q;

  // The aligner may only consume an address that is really there
  a_no_pop_empty : assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    afifo_pop_i |-> afifo_valid_o
  );

endmodule

// ==== design/sink_cmd_decode.sv ====
// Command decoder
`include "sink_params.svh"

module sink_cmd_decode (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  logic                    clear_i,
  input  logic                    cmd_valid_i,
  input  sink_pkg::cmd_op_e       cmd_op_i,
  input  logic [`SINK_ADDR_W-1:0] cmd_data_i,
  output logic [`SINK_ADDR_W-1:0] base_o,
  output logic [`SINK_ADDR_W-1:0] stride_o,
  output logic [`SINK_CNT_W-1:0]  len_o,
  output logic                    start_req_o
);

  logic [`SINK_ADDR_W-1:0] base_q;
  logic [`SINK_ADDR_W-1:0] stride_q;
  logic [`SINK_CNT_W-1:0]  len_q;
  logic                    start_req_q;

  // The command port is a plain strobe without back-pressure
  // Every sampled strobe is acted on in the same edge
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      base_q      <= '0;
      stride_q    <= '0;
      len_q       <= '0;
      start_req_q <= 1'b0;
    end else if (clear_i) begin
      base_q      <= '0;
      stride_q    <= '0;
      len_q       <= '0;
      start_req_q <= 1'b0;
    end else begin
      // The start request lives for one cycle only
      start_req_q <= 1'b0;
      if (cmd_valid_i) begin
        case (cmd_op_i)
          sink_pkg::OP_SET_BASE: begin
            base_q <= cmd_data_i;
          end
          sink_pkg::OP_SET_STRIDE: begin
            stride_q <= cmd_data_i;
          end
          sink_pkg::OP_SET_LEN: begin
            // Only the low half of the command word carries the length
            len_q <= cmd_data_i[`SINK_CNT_W-1:0];
          end
          sink_pkg::OP_START: begin
            // Back-to-back starts collapse into a single request pulse
            start_req_q <= !start_req_q;
          end
          default: begin
            start_req_q <= 1'b0;
          end
        endcase
      end
    end
  end

  assign base_o      = base_q;
  assign stride_o    = stride_q;
  assign len_o       = len_q;
  assign start_req_o = start_req_q;

  // The run controller sees each start as an isolated pulse
  a_start_req_pulse : assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    start_req_o |=> !start_req_o
  );

endmodule

// ==== design/sink_params.svh ====
// Store streamer parameters
`ifndef SINK_PARAMS_SVH
`define SINK_PARAMS_SVH

// Stream side data width, one 32-bit word per beat
`define SINK_STREAM_DW 32

// Memory side data width
// One extra word leaves room for a stream word shifted by up to three bytes
`define SINK_MEM_DW (`SINK_STREAM_DW + 32)

// Byte address width on the memory port
`define SINK_ADDR_W 32

// Width of the run length and of every store counter
`define SINK_CNT_W 16

// Number of generated addresses that may wait for a stream beat
`define SINK_AFIFO_DEPTH 2

`endif

// ==== design/sink_pkg.sv ====
// Store streamer types
`include "sink_params.svh"

package sink_pkg;

  // Opcodes of the command port
  // Each opcode either loads one configuration register or launches a run
  typedef enum logic [1:0] {
    // Byte address of the first store
    OP_SET_BASE   = 2'd0,
    // Byte distance between two consecutive stores, may be odd
    OP_SET_STRIDE = 2'd1,
    // Number of stores in one run
    OP_SET_LEN    = 2'd2,
    // Launch a run with the held configuration
    OP_START      = 2'd3
  } cmd_op_e;

  // States of the run controller
  typedef enum logic [1:0] {
    // Waiting for a start, ready_start is high here
    ST_IDLE    = 2'd0,
    // Addresses are still being generated
    ST_WORKING = 2'd1,
    // All addresses issued, waiting for the last stores to be granted
    ST_DRAIN   = 2'd2
  } run_state_e;

endpackage

// ==== design/sink_run_ctrl.sv ====
// Run controller
`include "sink_params.svh"

module sink_run_ctrl (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  logic                   clear_i,
  input  logic                   start_req_i,
  input  logic                   gen_done_i,
  input  logic                   store_fire_i,
  input  logic [`SINK_CNT_W-1:0] len_i,
  output logic                   gen_start_o,
  output logic                   active_o,
  output logic                   ready_start_o,
  output logic                   done_o
);

  sink_pkg::run_state_e    state_q;
  sink_pkg::run_state_e    state_d;
  logic [`SINK_CNT_W-1:0]  store_cnt_q;
  logic                    done_q;
  logic                    done_d;
  logic                    cnt_clr;
  logic                    can_start;

  // Not ready during the done pulse, so ready_start comes back one cycle later
  assign can_start = (state_q == sink_pkg::ST_IDLE) && !done_q;

  always_comb begin
    state_d     = state_q;
    done_d      = 1'b0;
    cnt_clr     = 1'b0;
    gen_start_o = 1'b0;
    case (state_q)
      sink_pkg::ST_IDLE: begin
        // A start while busy never reaches this branch and is dropped
        if (can_start && start_req_i) begin
          gen_start_o = 1'b1;
          state_d     = sink_pkg::ST_WORKING;
        end
      end
      sink_pkg::ST_WORKING: begin
        if (gen_done_i) begin
          state_d = sink_pkg::ST_DRAIN;
        end
      end
      sink_pkg::ST_DRAIN: begin
        // Every address has been issued, wait for the last grant
        if (store_cnt_q == len_i) begin
          state_d = sink_pkg::ST_IDLE;
          done_d  = 1'b1;
          cnt_clr = 1'b1;
        end
      end
      default: begin
        state_d = sink_pkg::ST_IDLE;
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q     <= sink_pkg::ST_IDLE;
      store_cnt_q <= '0;
      done_q      <= 1'b0;
    end else if (clear_i) begin
      // An aborted run ends without a done pulse
      state_q     <= sink_pkg::ST_IDLE;
      store_cnt_q <= '0;
      done_q      <= 1'b0;
    end else begin
      state_q <= state_d;
      done_q  <= done_d;
      if (cnt_clr) begin
        store_cnt_q <= '0;
      end else if (store_fire_i) begin
        store_cnt_q <= store_cnt_q + 1'b1;
      end
    end
  end

  assign active_o      = (state_q != sink_pkg::ST_IDLE);
  assign ready_start_o = can_start;
  assign done_o        = done_q;

  // Each run reports completion exactly once
  a_done_single : assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    done_o |=> !done_o
  );

endmodule

// ==== design/sink_store_align.sv ====
// Store data aligner
`include "sink_params.svh"

module sink_store_align (
  input  logic                        clk_i,
  input  logic                        rst_ni,
  input  logic                        active_i,
  input  logic                        stream_valid_i,
  input  logic                        afifo_valid_i,
  input  logic                        mem_gnt_i,
  input  logic [`SINK_STREAM_DW-1:0]  stream_data_i,
  input  logic [`SINK_STREAM_DW/8-1:0] stream_strb_i,
  input  logic [`SINK_ADDR_W-1:0]     afifo_addr_i,
  output logic                        stream_ready_o,
  output logic                        afifo_pop_o,
  output logic                        mem_req_o,
  output logic [`SINK_ADDR_W-1:0]     mem_addr_o,
  output logic [`SINK_MEM_DW/8-1:0]   mem_be_o,
  output logic [`SINK_MEM_DW-1:0]     mem_wdata_o
);

  localparam int unsigned PAD_DW = `SINK_MEM_DW - `SINK_STREAM_DW;
  localparam int unsigned PAD_BW = PAD_DW / 8;

  logic [1:0]                  byte_ofs;
  logic [`SINK_MEM_DW-1:0]     data_shifted;
  logic [`SINK_MEM_DW/8-1:0]   be_shifted;
  logic [`SINK_ADDR_W-1:0]     word_addr;

  // Byte position of the first stream byte inside the memory word
  assign byte_ofs = afifo_addr_i[1:0];

  // Zero extend the stream word, then move it up by whole bytes
  // Byte enables move by the same number of lanes as the data
  assign data_shifted = {{PAD_DW{1'b0}}, stream_data_i} << {byte_ofs, 3'b000};
  assign be_shifted   = {{PAD_BW{1'b0}}, stream_strb_i} << byte_ofs;

  // Memory sees word aligned addresses only
  assign word_addr = {afifo_addr_i[`SINK_ADDR_W-1:2], 2'b00};

  // A store needs a beat and an address at the same time
  assign mem_req_o   = active_i && stream_valid_i && afifo_valid_i;
  assign mem_addr_o  = active_i ? word_addr    : '0;
  assign mem_be_o    = active_i ? be_shifted   : '0;
  assign mem_wdata_o = active_i ? data_shifted : '0;

  // Idle bubbles on the stream are absorbed, a real beat waits for the grant
  assign stream_ready_o = active_i && (!stream_valid_i || (mem_gnt_i && afifo_valid_i));

  // A transferred beat retires the address it was paired with
  assign afifo_pop_o = stream_valid_i && stream_ready_o;

  // A request without grant keeps its address until memory takes it
  // Only a clear, which drops active, may withdraw it
  a_req_addr_stable : assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    (mem_req_o && !mem_gnt_i) |=> (!active_i || (mem_req_o && $stable(mem_addr_o)))
  );

endmodule

// ==== design/sink_top.sv ====
// Store streamer top level
`include "sink_params.svh"

module sink_top (
  input  logic                         clk_i,
  input  logic                         rst_ni,
  input  logic                         clear_i,
  // Command strobe
  input  logic                         cmd_valid_i,
  input  sink_pkg::cmd_op_e            cmd_op_i,
  input  logic [`SINK_ADDR_W-1:0]      cmd_data_i,
  // Incoming data stream
  input  logic                         stream_valid_i,
  input  logic [`SINK_STREAM_DW-1:0]   stream_data_i,
  input  logic [`SINK_STREAM_DW/8-1:0] stream_strb_i,
  output logic                         stream_ready_o,
  // Memory store port
  output logic                         mem_req_o,
  input  logic                         mem_gnt_i,
  output logic [`SINK_ADDR_W-1:0]      mem_addr_o,
  output logic [`SINK_MEM_DW/8-1:0]    mem_be_o,
  output logic [`SINK_MEM_DW-1:0]      mem_wdata_o,
  // Status
  output logic                         ready_start_o,
  output logic                         done_o
);

  logic                    start_req;
  logic [`SINK_ADDR_W-1:0] base;
  logic [`SINK_ADDR_W-1:0] stride;
  logic [`SINK_CNT_W-1:0]  len;
  logic                    gen_start;
  logic                    gen_done;
  logic                    afifo_valid;
  logic [`SINK_ADDR_W-1:0] afifo_addr;
  // Popping an address and completing a store are the same event
  logic                    afifo_pop;
  logic                    active;

  sink_cmd_decode i_cmd_decode (
    .clk_i       ( clk_i       ),
    .rst_ni      ( rst_ni      ),
    .clear_i     ( clear_i     ),
    .cmd_valid_i ( cmd_valid_i ),
    .cmd_op_i    ( cmd_op_i    ),
    .cmd_data_i  ( cmd_data_i  ),
    .base_o      ( base        ),
    .stride_o    ( stride      ),
    .len_o       ( len         ),
    .start_req_o ( start_req   )
  );

  sink_addr_gen i_addr_gen (
    .clk_i         ( clk_i       ),
    .rst_ni        ( rst_ni      ),
    .clear_i       ( clear_i     ),
    .gen_start_i   ( gen_start   ),
    .base_i        ( base        ),
    .stride_i      ( stride      ),
    .len_i         ( len         ),
    .afifo_pop_i   ( afifo_pop   ),
    .afifo_valid_o ( afifo_valid ),
    .afifo_addr_o  ( afifo_addr  ),
    .gen_done_o    ( gen_done    )
  );

  sink_store_align i_store_align (
    .clk_i          ( clk_i          ),
    .rst_ni         ( rst_ni         ),
    .active_i       ( active         ),
    .stream_valid_i ( stream_valid_i ),
    .afifo_valid_i  ( afifo_valid    ),
    .mem_gnt_i      ( mem_gnt_i      ),
    .stream_data_i  ( stream_data_i  ),
    .stream_strb_i  ( stream_strb_i  ),
    .afifo_addr_i   ( afifo_addr     ),
    .stream_ready_o ( stream_ready_o ),
    .afifo_pop_o    ( afifo_pop      ),
    .mem_req_o      ( mem_req_o      ),
    .mem_addr_o     ( mem_addr_o     ),
    .mem_be_o       ( mem_be_o       ),
    .mem_wdata_o    ( mem_wdata_o    )
  );

  sink_run_ctrl i_run_ctrl (
    .clk_i         ( clk_i         ),
    .rst_ni        ( rst_ni        ),
    .clear_i       ( clear_i       ),
    .start_req_i   ( start_req     ),
    .gen_done_i    ( gen_done      ),
    .store_fire_i  ( afifo_pop     ),
    .len_i         ( len           ),
    .gen_start_o   ( gen_start     ),
    .active_o      ( active        ),
    .ready_start_o ( ready_start_o ),
    .done_o        ( done_o        )
  );

endmodule

// ==== dv/tb_sink_top.sv ====
// Store streamer testbench
`include "sink_params.svh"

module tb_sink_top;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int unsigned MAX_BEATS  = 64;
  localparam int unsigned WAIT_LIMIT = 2000;

  logic                         clk_i;
  logic                         rst_ni;
  logic                         clear_i;
  logic                         cmd_valid_i;
  sink_pkg::cmd_op_e            cmd_op_i;
  logic [`SINK_ADDR_W-1:0]      cmd_data_i;
  logic                         stream_valid_i;
  logic [`SINK_STREAM_DW-1:0]   stream_data_i;
  logic [`SINK_STREAM_DW/8-1:0] stream_strb_i;
  logic                         stream_ready_o;
  logic                         mem_req_o;
  logic                         mem_gnt_i;
  logic [`SINK_ADDR_W-1:0]      mem_addr_o;
  logic [`SINK_MEM_DW/8-1:0]    mem_be_o;
  logic [`SINK_MEM_DW-1:0]      mem_wdata_o;
  logic                         ready_start_o;
  logic                         done_o;

  // Configuration and stream contents of the run under test
  logic [31:0] run_base;
  logic [31:0] run_stride;
  int unsigned run_len;
  logic [31:0] beat_data [MAX_BEATS];
  logic [3:0]  beat_strb [MAX_BEATS];

  // Byte image that the memory model builds from granted stores
  logic [7:0]  mem_img [logic [31:0]];
  int unsigned gnt_pct;
  int unsigned store_cnt;
  int unsigned done_cnt;
  int unsigned err_cnt;
  int unsigned test_cnt;
  int unsigned fail_cnt;

  sink_top sink_top_i (.*);

  initial begin
    clk_i = 1'b0;
    forever begin
      #20 clk_i = ~clk_i;
    end
  end

  // Expected content of one byte as {written, value}
  // Stores land in stream order, so a later beat wins on overlap
  function automatic logic [8:0] ref_byte(input logic [31:0] addr);
    logic [8:0]  res;
    logic [31:0] beat_addr;
    int unsigned i;
    int unsigned j;
    res = 9'h000;
    for (i = 0; i < run_len; i++) begin
      beat_addr = run_base + i * run_stride;
      for (j = 0; j < 4; j++) begin
        if (beat_strb[i][j] && (beat_addr + j == addr)) begin
          res = {1'b1, beat_data[i][8*j +: 8]};
        end
      end
    end
    return res;
  endfunction

  // Expected {word address, byte enables} of store number k
  function automatic logic [39:0] ref_store(input int unsigned k);
    logic [31:0] addr;
    logic [7:0]  be;
    int unsigned j;
    addr = run_base + k * run_stride;
    // Stream byte j lands in memory lane j plus the address offset
    be   = 8'h00;
    for (j = 0; j < 4; j++) begin
      be[addr[1:0] + j] = beat_strb[k][j];
    end
    return {addr[31:2], 2'b00, be};
  endfunction

  task automatic check_val(input string name, input logic [63:0] got, input logic [63:0] exp);
    if (got !== exp) begin
      $display("error at %0t ns: %s is %h, expected %h", $time, name, got, exp);
      err_cnt++;
    end
  endtask

  task automatic report_test(input string name, input int unsigned err_before);
    test_cnt++;
    if (err_cnt != err_before) begin
      fail_cnt++;
    end
    $display("test %0d %s: %s", test_cnt, name, (err_cnt == err_before) ? "ok" : "FAILED");
  endtask

  // Memory model, grants at random and checks each store as it completes
  always @(negedge clk_i) begin
    mem_gnt_i = ($urandom_range(99, 0) < gnt_pct);
  end

  always @(posedge clk_i) begin
    logic [39:0] exp_st;
    int unsigned b;
    if (rst_ni && mem_req_o && mem_gnt_i) begin
      if (store_cnt < run_len) begin
        exp_st = ref_store(store_cnt);
        check_val("mem_addr_o", mem_addr_o, exp_st[39:8]);
        check_val("mem_be_o", mem_be_o, exp_st[7:0]);
      end else begin
        $display("Store granted beyond the run length at %0t ns", $time);
        err_cnt++;
      end
      for (b = 0; b < 8; b++) begin
        if (mem_be_o[b]) begin
          mem_img[mem_addr_o + b] = mem_wdata_o[8*b +: 8];
        end
      end
      store_cnt++;
    end
    if (done_o) begin
      done_cnt++;
    end
  end

  task automatic send_cmd(input sink_pkg::cmd_op_e op, input logic [31:0] data);
    @(negedge clk_i);
    cmd_valid_i = 1'b1;
    cmd_op_i    = op;
    cmd_data_i  = data;
    @(negedge clk_i);
    cmd_valid_i = 1'b0;
  endtask

  // Drives n beats, each held until the DUT takes it
  task automatic send_beats(input int unsigned n, input bit gaps);
    int unsigned i;
    int unsigned k;
    bit          taken;
    taken = 1'b1;
    for (i = 0; i < n && taken; i++) begin
      repeat (gaps ? $urandom_range(3, 0) : 0) begin
        @(negedge clk_i);
        stream_valid_i = 1'b0;
      end
      @(negedge clk_i);
      stream_valid_i = 1'b1;
      stream_data_i  = beat_data[i];
      stream_strb_i  = beat_strb[i];
      taken = 1'b0;
      for (k = 0; k < WAIT_LIMIT && !taken; k++) begin
        @(posedge clk_i);
        taken = stream_ready_o;
      end
      if (!taken) begin
        $display("Timeout: stream beat %0d was never accepted", i);
        err_cnt++;
      end
    end
    @(negedge clk_i);
    stream_valid_i = 1'b0;
  endtask

  task automatic wait_done();
    int unsigned k;
    bit          seen;
    seen = 1'b0;
    for (k = 0; k < WAIT_LIMIT && !seen; k++) begin
      @(posedge clk_i);
      seen = done_o;
    end
    if (!seen) begin
      $display("Timeout: no done pulse for the run at base %h", run_base);
      err_cnt++;
    end
  endtask

  // Loads a fresh run configuration and random beats, then starts it
  task automatic launch_run(input logic [31:0] base, input logic [31:0] stride,
                            input int unsigned len, input bit partial);
    int unsigned i;
    run_base   = base;
    run_stride = stride;
    run_len    = len;
    for (i = 0; i < len; i++) begin
      beat_data[i] = $urandom();
      beat_strb[i] = partial ? 4'($urandom_range(15, 0)) : 4'hf;
    end
    mem_img.delete();
    store_cnt = 0;
    done_cnt  = 0;
    send_cmd(sink_pkg::OP_SET_BASE, base);
    send_cmd(sink_pkg::OP_SET_STRIDE, stride);
    send_cmd(sink_pkg::OP_SET_LEN, len);
    send_cmd(sink_pkg::OP_START, 32'h0);
  endtask

  task automatic run_test(input string name, input logic [31:0] base, input logic [31:0] stride,
                          input int unsigned len, input bit partial, input bit gaps,
                          input int unsigned gnt, input bit extra_start);
    int unsigned err_before;
    int unsigned in_range;
    logic [31:0] x;
    logic [31:0] hi;
    logic [8:0]  got;
    err_before = err_cnt;
    gnt_pct    = gnt;
    launch_run(base, stride, len, partial);
    fork
      send_beats(len, gaps);
      wait_done();
      if (extra_start) begin
        // A second start lands while the run is still working
        repeat (3) @(negedge clk_i);
        send_cmd(sink_pkg::OP_START, 32'h0);
      end
    join
    @(posedge clk_i);
    check_val("ready_start_o", ready_start_o, 1'b1);
    check_val("done_o", done_o, 1'b0);
    repeat (6) @(posedge clk_i);
    check_val("done pulses", done_cnt, 1);
    check_val("granted stores", store_cnt, len);
    check_val("mem_req_o", mem_req_o, 1'b0);
    // Scan a margin around the footprint so that stray writes show up
    hi       = base + (len - 1) * stride + 8;
    in_range = 0;
    for (x = base - 4; x != hi; x++) begin
      got = mem_img.exists(x) ? {1'b1, mem_img[x]} : 9'h000;
      check_val($sformatf("mem[%h]", x), got, ref_byte(x));
      if (mem_img.exists(x)) begin
        in_range++;
      end
    end
    check_val("bytes written", mem_img.num(), in_range);
    report_test(name, err_before);
  endtask

  initial begin
    int unsigned err_before;
    void'($urandom(32'hfcb9));
    rst_ni         = 1'b0;
    clear_i        = 1'b0;
    cmd_valid_i    = 1'b0;
    cmd_op_i       = sink_pkg::OP_SET_BASE;
    cmd_data_i     = '0;
    stream_valid_i = 1'b0;
    stream_data_i  = '0;
    stream_strb_i  = '0;
    mem_gnt_i      = 1'b0;
    gnt_pct        = 100;
    run_len        = 0;
    err_cnt        = 0;
    test_cnt       = 0;
    fail_cnt       = 0;
    repeat (10) @(negedge clk_i);
    rst_ni = 1'b1;

    err_before = err_cnt;
    @(posedge clk_i);
    check_val("ready_start_o", ready_start_o, 1'b1);
    check_val("mem_req_o", mem_req_o, 1'b0);
    check_val("stream_ready_o", stream_ready_o, 1'b0);
    check_val("done_o", done_o, 1'b0);
    report_test("reset values", err_before);

    run_test("aligned run", 32'h100, 32'd4, 8, 1'b0, 1'b0, 100, 1'b0);
    run_test("misaligned, stride 5", 32'h203, 32'd5, 10, 1'b1, 1'b0, 100, 1'b0);
    run_test("misaligned, stride 7", 32'h301, 32'd7, 9, 1'b1, 1'b0, 100, 1'b0);
    run_test("gaps and back-pressure", 32'h402, 32'd3, 16, 1'b1, 1'b1, 50, 1'b0);
    run_test("start while busy", 32'h505, 32'd9, 12, 1'b1, 1'b1, 70, 1'b1);

    // Abort a run after four of its twenty stores
    err_before = err_cnt;
    gnt_pct    = 100;
    launch_run(32'h600, 32'd4, 20, 1'b0);
    send_beats(4, 1'b0);
    @(negedge clk_i);
    clear_i = 1'b1;
    @(negedge clk_i);
    clear_i = 1'b0;
    // Beats offered after the abort must not reach memory
    stream_valid_i = 1'b1;
    stream_data_i  = beat_data[4];
    stream_strb_i  = beat_strb[4];
    @(posedge clk_i);
    check_val("ready_start_o", ready_start_o, 1'b1);
    check_val("mem_req_o", mem_req_o, 1'b0);
    check_val("stream_ready_o", stream_ready_o, 1'b0);
    repeat (8) @(posedge clk_i);
    check_val("done pulses", done_cnt, 0);
    check_val("granted stores", store_cnt, 4);
    @(negedge clk_i);
    stream_valid_i = 1'b0;
    report_test("clear in mid-run", err_before);

    $display("%0d tests run, %0d failed, %0d errors", test_cnt, fail_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule

// ==== files.f ====
+incdir+design
design/sink_pkg.sv
design/sink_cmd_decode.sv
design/sink_addr_gen.sv
design/sink_store_align.sv
design/sink_run_ctrl.sv
design/sink_top.sv
dv/tb_sink_top.sv
